//--- verilog.f
+incdir+source
source/clkdiv_pkg.sv
source/clkdiv_cfg_port.sv
source/clk_int_div.sv
source/clk_out_stage.sv
source/clkdiv_top.sv
tb/tb_clkdiv.sv

//--- Bender.yml
package:
  name: clkdiv

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/clkdiv_pkg.sv
      - source/clkdiv_cfg_port.sv
      - source/clk_int_div.sv
      - source/clk_out_stage.sv
      - source/clkdiv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clkdiv.sv

//--- tb/tb_clkdiv.sv
// Testbench of the runtime-configurable clock divider
// Builds a stimulus table of config writes with expected clk_o timing,
// applies it in a loop and measures period and high time of clk_o
// Also covers reset idle, dropped writes, disable and test mode

`timescale 1ns/1ps

`include "clkdiv_settings.svh"

module tb_clkdiv;

  import clkdiv_pkg::*;

  // One stimulus line with the timing that clk_o must show afterwards
  // A zero period means clk_o has to stay low
  typedef struct packed {
    cfg_kind_e                    kind;
    logic [`CLKDIV_DIV_WIDTH-1:0] div;
    logic                         en;
    logic                         test_mode;
    logic                         late_we;
    logic [`CLKDIV_DIV_WIDTH-1:0] late_div;
    int                           exp_period;
    int                           exp_high;
  } entry_t;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         test_mode_en_i;
  logic                         cfg_we_i;
  cfg_word_u                    cfg_word_i;
  logic                         cfg_busy_o;
  logic                         clk_o;
  logic [`CLKDIV_DIV_WIDTH-1:0] cycl_count_o;

  entry_t stim_q[$];
  bit     stim_ready = 1'b0;
  int     seed = 27;

  clkdiv_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .test_mode_en_i ( test_mode_en_i ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_word_i     ( cfg_word_i     ),
    .cfg_busy_o     ( cfg_busy_o     ),
    .clk_o          ( clk_o          ),
    .cycl_count_o   ( cycl_count_o   )
  );

  // Input clock with a 4 ns period
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0.3f ns: %s is %0d, expected %0d", $realtime, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Output period in ns for a divider value, 0 and 1 pass clk_i through
  function automatic int period_for(input int div);
    return (div < 2) ? 4 : div * 4;
  endfunction

  function automatic cfg_word_u make_word(input cfg_kind_e kind, input int div, input logic en);
    cfg_word_u w;
    w = '0;
    if (kind == CFG_DIV) begin
      w.div_w.kind = CFG_DIV;
      w.div_w.div  = div[`CLKDIV_DIV_WIDTH-1:0];
    end else begin
      w.ctrl_w.kind = CFG_CTRL;
      w.ctrl_w.en   = en;
    end
    return w;
  endfunction

  task automatic add_entry(input cfg_kind_e kind, input int div, input logic en,
                           input logic tm, input logic late_we, input int late_div,
                           input int exp_period);
    entry_t e;
    e.kind       = kind;
    e.div        = div[`CLKDIV_DIV_WIDTH-1:0];
    e.en         = en;
    e.test_mode  = tm;
    e.late_we    = late_we;
    e.late_div   = late_div[`CLKDIV_DIV_WIDTH-1:0];
    e.exp_period = exp_period;
    e.exp_high   = exp_period / 2;
    stim_q.push_back(e);
  endtask

  // Writes the entry's word, optionally a second word while busy,
  // then waits for the pending request to be taken
  task automatic apply_entry(input entry_t e);
    @(posedge clk_i);
    #1;
    test_mode_en_i = e.test_mode;
    cfg_word_i     = make_word(e.kind, e.div, e.en);
    cfg_we_i       = 1'b1;
    @(posedge clk_i);
    #1;
    if (e.late_we) begin
      check_eq("cfg_busy_o before second write", cfg_busy_o, 1);
      cfg_word_i = make_word(CFG_DIV, e.late_div, 1'b0);
      @(posedge clk_i);
      #1;
    end
    cfg_we_i = 1'b0;
    while (cfg_busy_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Skips two rising edges, then times one full clk_o period
  task automatic measure(output real period, output real high);
    real t_rise, t_fall, t_next;
    repeat (2) @(posedge clk_o);
    @(posedge clk_o);
    t_rise = $realtime;
    @(negedge clk_o);
    t_fall = $realtime;
    @(posedge clk_o);
    t_next = $realtime;
    period = t_next - t_rise;
    high   = t_fall - t_rise;
  endtask

  // Gives the old clock one long period to finish, then samples both phases
  // The cycle counter keeps wrapping at the divider behind the shut gate
  task automatic check_held_low(input int div);
    int first;
    int k;
    repeat (16) @(posedge clk_i);
    k     = 0;
    first = 0;
    repeat (20) begin
      @(posedge clk_i);
      #1;
      if (k == 0) begin
        first = cycl_count_o;
      end
      check_eq("clk_o while disabled", clk_o, 0);
      check_eq("cycl_count_o while disabled", cycl_count_o,
               (div < 2) ? 0 : (first + k) % div);
      k++;
      #2;
      check_eq("clk_o while disabled", clk_o, 0);
    end
  endtask

  // --------------------------------------------------
  // Watchdog

  // Budget per entry covers the wait for busy and three slow periods
  initial begin
    int limit;
    wait (stim_ready);
    limit = stim_q.size() * 3 * 15 + 100;
    repeat (limit) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, clk_o stopped toggling", limit);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation timed out");
  end

  // --------------------------------------------------
  // Main sequence

  initial begin
    real    period, high;
    int     d;
    int     cur_div;
    entry_t e;

    rst_ni         = 1'b0;
    test_mode_en_i = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_word_i     = '0;

    // Enable first, since a divider request waits while the clock is off
    add_entry(CFG_CTRL, 0, 1'b1, 1'b0, 1'b0, 0, period_for(`CLKDIV_DEFAULT_DIV));
    add_entry(CFG_DIV, 2, 1'b0, 1'b0, 1'b0, 0, period_for(2));
    add_entry(CFG_DIV, 4, 1'b0, 1'b0, 1'b0, 0, period_for(4));
    add_entry(CFG_DIV, 14, 1'b0, 1'b0, 1'b0, 0, period_for(14));
    add_entry(CFG_DIV, 3, 1'b0, 1'b0, 1'b0, 0, period_for(3));
    add_entry(CFG_DIV, 5, 1'b0, 1'b0, 1'b0, 0, period_for(5));
    add_entry(CFG_DIV, 15, 1'b0, 1'b0, 1'b0, 0, period_for(15));
    add_entry(CFG_DIV, 0, 1'b0, 1'b0, 1'b0, 0, period_for(0));
    add_entry(CFG_DIV, 1, 1'b0, 1'b0, 1'b0, 0, period_for(1));
    repeat (4) begin
      d = 2 + ($unsigned($random(seed)) % 14);
      add_entry(CFG_DIV, d, 1'b0, 1'b0, 1'b0, 0, period_for(d));
    end
    // The second word lands while busy and must not change the period
    add_entry(CFG_DIV, 6, 1'b0, 1'b0, 1'b1, 10, period_for(6));
    add_entry(CFG_CTRL, 0, 1'b0, 1'b0, 1'b0, 0, 0);
    add_entry(CFG_CTRL, 0, 1'b0, 1'b1, 1'b0, 0, 4);
    stim_ready = 1'b1;

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Clock is still disabled after reset
    // Default divider is bypass, so the counter rests at zero
    repeat (20) begin
      @(posedge clk_i);
      #1;
      check_eq("clk_o after reset", clk_o, 0);
      check_eq("cfg_busy_o after reset", cfg_busy_o, 0);
      check_eq("cycl_count_o after reset", cycl_count_o, 0);
    end

    cur_div = `CLKDIV_DEFAULT_DIV;
    foreach (stim_q[i]) begin
      e = stim_q[i];
      apply_entry(e);
      if (e.kind == CFG_DIV) begin
        cur_div = e.div;
      end
      if (e.exp_period == 0) begin
        check_held_low(cur_div);
      end else begin
        measure(period, high);
        check_eq("clk_o period in ps", int'(period * 1000.0), e.exp_period * 1000);
        check_eq("clk_o high time in ps", int'(high * 1000.0), e.exp_high * 1000);
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- source/clkdiv_top.sv
// Top level of the runtime-configurable clock divider
// Config port, divider core and output stage

`timescale 1ns/1ps

`include "clkdiv_settings.svh"

module clkdiv_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          test_mode_en_i,
  input  logic                          cfg_we_i,
  input  clkdiv_pkg::cfg_word_u         cfg_word_i,
  output logic                          cfg_busy_o,
  output logic                          clk_o,
  output logic [`CLKDIV_DIV_WIDTH-1:0]  cycl_count_o
);

  import clkdiv_pkg::*;

  div_req_t      div_req;
  div_clk_ctrl_t div_ctrl;
  logic          div_ready;
  logic          clk_en;

  clkdiv_cfg_port i_cfg_port (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .cfg_we_i    ( cfg_we_i   ),
    .cfg_word_i  ( cfg_word_i ),
    .div_ready_i ( div_ready  ),
    .div_req_o   ( div_req    ),
    .en_o        ( clk_en     ),
    .cfg_busy_o  ( cfg_busy_o )
  );

  clk_int_div i_clk_int_div (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .en_i         ( clk_en       ),
    .div_req_i    ( div_req      ),
    .div_ready_o  ( div_ready    ),
    .ctrl_o       ( div_ctrl     ),
    .cycl_count_o ( cycl_count_o )
  );

  clk_out_stage i_out_stage (
    .clk_i          ( clk_i          ),
    .test_mode_en_i ( test_mode_en_i ),
    .ctrl_i         ( div_ctrl       ),
    .clk_o          ( clk_o          )
  );

endmodule

//--- source/clk_out_stage.sv
// Output stage of the clock divider
// Odd clock from the two toggles, even/odd and bypass selection,
// and the latch-based glitch-free gate with test-mode override

`timescale 1ns/1ps

module clk_out_stage (
  input  logic                      clk_i,
  input  logic                      test_mode_en_i,
  input  clkdiv_pkg::div_clk_ctrl_t ctrl_i,
  output logic                      clk_o
);

  logic odd_clk;
  logic div_clk;
  logic sel_clk;
  logic en_latched;

  // --------------------------------------------------
  // Clock selection

  // Rising-edge toggle xor falling-edge toggle gives the odd 50% clock
  assign odd_clk = ctrl_i.even_tgl ^ ctrl_i.odd_tgl;

  assign div_clk = ctrl_i.use_odd ? odd_clk : ctrl_i.even_tgl;

  // Divide by 0 or 1 and test mode both take the input clock
  assign sel_clk = (ctrl_i.bypass || test_mode_en_i) ? clk_i : div_clk;

  // --------------------------------------------------
  // Glitch-free gate

  // Enable only moves while the selected clock is low,
  // so a change never cuts a high phase short
  always_latch begin
    if (!sel_clk) begin
      en_latched = ctrl_i.gate_en;
    end
  end

  // Test mode forces the gate open without waiting for a low phase
  assign clk_o = sel_clk & (en_latched | test_mode_en_i);

  // A closed gate may only let a falling edge through
  a_no_rise_gated : assert property (@(posedge clk_o) disable iff (test_mode_en_i)
    ctrl_i.gate_en);

endmodule

//--- source/clk_int_div.sv
// Integer divider core
// Load FSM that swaps the divider behind a closed gate,
// wrapping cycle counter and the two toggle flip-flops
// that the output stage combines into even or odd clocks

`timescale 1ns/1ps

`include "clkdiv_settings.svh"

module clk_int_div (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  clkdiv_pkg::div_req_t          div_req_i,
  output logic                          div_ready_o,
  output clkdiv_pkg::div_clk_ctrl_t     ctrl_o,
  output logic [`CLKDIV_DIV_WIDTH-1:0]  cycl_count_o
);

  localparam int unsigned     cnt_w      = `CLKDIV_DIV_WIDTH;
  localparam logic [cnt_w-1:0] cnt_one    = 1;
  localparam logic [cnt_w-1:0] div_rst    = `CLKDIV_DEFAULT_DIV;
  localparam logic            bypass_rst = (`CLKDIV_DEFAULT_DIV < 2);
  localparam logic            gate_rst   = `CLKDIV_CLK_IN_RESET;

  typedef enum logic [1:0] {
    IDLE, LOAD_DIV, WAIT_START_PERIOD, WAIT_END_PERIOD
  } load_state_e;

  load_state_e      state_d, state_q;
  logic [cnt_w-1:0] div_d, div_q;
  logic [cnt_w-1:0] cnt_d, cnt_q;
  logic [cnt_w-1:0] half_even, half_odd;
  logic             use_odd_d, use_odd_q;
  logic             bypass_d, bypass_q;
  logic             gate_en_d, gate_en_q;
  logic             t1_q, t2_q, t1_en, t2_en;
  logic             gen_clk_lvl;

  if ($clog2(`CLKDIV_DEFAULT_DIV + 1) > cnt_w) begin : gen_div_check
    $error("Default divider does not fit into %0d counter bits", cnt_w);
  end

  // --------------------------------------------------
  // Load FSM

  // Level of the divided clock before the gate
  assign gen_clk_lvl = use_odd_q ? (t1_q ^ t2_q) : t1_q;

  always_comb begin
    state_d     = state_q;
    div_d       = div_q;
    use_odd_d   = use_odd_q;
    bypass_d    = bypass_q;
    gate_en_d   = 1'b0;
    div_ready_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (en_i && div_req_i.valid) begin
          state_d = LOAD_DIV;
        end else begin
          gate_en_d = en_i;
        end
      end
      LOAD_DIV: begin
        // The closed gate has been latched once the clock is low,
        // from then on the divider can change without reaching clk_o
        if (!gen_clk_lvl || bypass_q) begin
          div_ready_o = 1'b1;
          div_d       = div_req_i.div;
          use_odd_d   = div_req_i.div[0];
          bypass_d    = (div_req_i.div < 2);
          state_d     = WAIT_START_PERIOD;
        end
      end
      WAIT_START_PERIOD: begin
        if (cnt_q == '0) begin
          state_d = WAIT_END_PERIOD;
        end
      end
      WAIT_END_PERIOD: begin
        // One full new period has run behind the gate
        if (bypass_q || (cnt_q == div_q - cnt_one)) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      div_q     <= div_rst;
      use_odd_q <= div_rst[0];
      bypass_q  <= bypass_rst;
      gate_en_q <= gate_rst;
    end else begin
      state_q   <= state_d;
      div_q     <= div_d;
      use_odd_q <= use_odd_d;
      bypass_q  <= bypass_d;
      gate_en_q <= gate_en_d;
    end
  end

  // --------------------------------------------------
  // Cycle counter

  // Restarts on a load, wraps at div-1 and rests at zero in bypass
  always_comb begin
    if (div_ready_o || bypass_q || (cnt_q == div_q - cnt_one)) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + cnt_one;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cycl_count_o = cnt_q;

  // --------------------------------------------------
  // Toggle flip-flops

  // Even division toggles at 0 and div/2, odd division toggles the
  // rising-edge flop at 0 and the falling-edge flop at (div+1)/2
  assign half_even = div_q >> 1;
  assign half_odd  = half_even + cnt_one;

  always_comb begin
    t1_en = 1'b0;
    t2_en = 1'b0;
    if (!bypass_q) begin
      if (use_odd_q) begin
        t1_en = (cnt_q == '0);
        t2_en = (cnt_q == half_odd);
      end else begin
        t1_en = (cnt_q == '0) || (cnt_q == half_even);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      t1_q <= 1'b0;
    end else if (t1_en) begin
      t1_q <= !t1_q;
    end
  end

  always_ff @(negedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      t2_q <= 1'b0;
    end else if (t2_en) begin
      t2_q <= !t2_q;
    end
  end

  assign ctrl_o.even_tgl = t1_q;
  assign ctrl_o.odd_tgl  = t2_q;
  assign ctrl_o.use_odd  = use_odd_q;
  assign ctrl_o.bypass   = bypass_q;
  assign ctrl_o.gate_en  = gate_en_q;

  a_ready_in_load : assert property (@(posedge clk_i) disable iff (!rst_ni)
    div_ready_o |-> (state_q == LOAD_DIV));

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, LOAD_DIV, WAIT_START_PERIOD, WAIT_END_PERIOD});

  // The gate stays shut for the whole transition
  a_gate_closed : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != IDLE) |-> !gate_en_q);

endmodule

//--- source/clkdiv_cfg_port.sv
// Configuration input of the clock divider
// Decodes single-word writes into the enable level or a divider request
// and holds the request until the divider core accepts it

`timescale 1ns/1ps

module clkdiv_cfg_port (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  clkdiv_pkg::cfg_word_u cfg_word_i,
  input  logic                  div_ready_i,
  output clkdiv_pkg::div_req_t  div_req_o,
  output logic                  en_o,
  output logic                  cfg_busy_o
);

  import clkdiv_pkg::*;

  logic     div_write;
  logic     ctrl_write;
  logic     en_q;
  div_req_t req_q;

  // --------------------------------------------------
  // Write decode

  // Both views keep the kind in the same bit
  assign div_write  = cfg_we_i && (cfg_word_i.div_w.kind == CFG_DIV);
  assign ctrl_write = cfg_we_i && (cfg_word_i.ctrl_w.kind == CFG_CTRL);

  // Enable level follows every control write at the next edge
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      en_q <= 1'b0;
    end else if (ctrl_write) begin
      en_q <= cfg_word_i.ctrl_w.en;
    end
  end

  // --------------------------------------------------
  // Pending request

  // Valid rises on an accepted div write and drops on the handshake
  // A div write that finds a pending request is lost
  // The divider value is only captured while nothing is pending
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= '0;
    end else if (req_q.valid) begin
      if (div_ready_i) begin
        req_q.valid <= 1'b0;
      end
    end else if (div_write) begin
      req_q.valid <= 1'b1;
      req_q.div   <= cfg_word_i.div_w.div;
    end
  end

  assign div_req_o  = req_q;
  assign en_o       = en_q;
  // Busy is the pending flag itself, so it falls on the edge after ready
  assign cfg_busy_o = req_q.valid;

  // A request that waits for the core must not move under it
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_q.valid && !div_ready_i) |=> $stable(req_q));

endmodule

//--- source/clkdiv_pkg.sv
// Shared types of the clock divider
// Configuration word with its divider and control views,
// divider request from the config port to the core and
// toggle/select bundle from the core to the output stage

`include "clkdiv_settings.svh"

package clkdiv_pkg;

  // Top bit of every configuration word
  typedef enum logic {
    CFG_DIV  = 1'b0,
    CFG_CTRL = 1'b1
  } cfg_kind_e;

  // Divider view, the low bits carry the new division factor
  typedef struct packed {
    cfg_kind_e                     kind;
    logic [6-`CLKDIV_DIV_WIDTH:0]  rsvd;
    logic [`CLKDIV_DIV_WIDTH-1:0]  div;
  } cfg_div_word_t;

  // Control view, bit 0 is the output clock enable
  typedef struct packed {
    cfg_kind_e  kind;
    logic [5:0] rsvd;
    logic       en;
  } cfg_ctrl_word_t;

  // One written word, the kind bit selects which view applies
  typedef union packed {
    cfg_div_word_t  div_w;
    cfg_ctrl_word_t ctrl_w;
  } cfg_word_u;

  // Pending divider change, held until the core accepts it
  typedef struct packed {
    logic                         valid;
    logic [`CLKDIV_DIV_WIDTH-1:0] div;
  } div_req_t;

  // Registered state that the output stage turns into clk_o
  typedef struct packed {
    logic even_tgl;
    logic odd_tgl;
    logic use_odd;
    logic bypass;
    logic gate_en;
  } div_clk_ctrl_t;

endpackage

//--- source/clkdiv_settings.svh
// Build-time settings of the runtime-configurable clock divider
// Counter width, divider after reset and clock enable during reset

`ifndef CLKDIV_SETTINGS_SVH
`define CLKDIV_SETTINGS_SVH

// Width of the divider value and of the cycle counter
// Sets the largest division factor as 2**width-1
`define CLKDIV_DIV_WIDTH 4

// Divider in use right after reset
// Values 0 and 1 both select the bypass path
`define CLKDIV_DEFAULT_DIV 1

// When 1 the output gate is already open while reset is asserted
// and the default divider clocks right from the start
`define CLKDIV_CLK_IN_RESET 0

`endif
